/* capture/capture_fsm.sv */
`timescale 1ns/1ps

module capture_fsm #(
    parameter int FRAME_PIXELS = 64
) (
    input  logic clock_in,
    input  logic reset_n_in,
    input  logic start_capture,
    input  logic power_save_enable,
    input  logic frame_start_in,
    input  logic pixel_valid_in,
    input  logic keep_pixel,
    input  logic frame_done,
    output logic count_enable,
    output logic count_clear,
    output logic write_enable,
    output logic image_ready
);

    camera_pkg::capture_state_t state;

    assign count_enable = (state == camera_pkg::CAPTURE) && pixel_valid_in;
    assign count_clear = (state == camera_pkg::WAIT_FRAME);
    assign write_enable = count_enable && keep_pixel;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            state <= camera_pkg::IDLE;
            image_ready <= 1'b0;
        end else begin
            case (state)
                camera_pkg::IDLE, camera_pkg::DONE: begin
                    if (start_capture && !power_save_enable) begin
                        state <= camera_pkg::WAIT_FRAME;
                        image_ready <= 1'b0;
                    end
                end
                camera_pkg::WAIT_FRAME: begin
                    if (frame_start_in) begin
                        state <= camera_pkg::CAPTURE;
                    end
                end
                camera_pkg::CAPTURE: begin
                    if (count_enable && frame_done) begin
                        state <= camera_pkg::DONE;
                        image_ready <= 1'b1;
                    end
                end
                default: state <= camera_pkg::IDLE;
            endcase
        end
    end

endmodule

/* capture/image_buffer.sv */
`timescale 1ns/1ps

module image_buffer #(
    parameter int FRAME_PIXELS = 64
) (
    input  logic                   clock_in,
    input  logic                   write_enable,
    input  logic [15:0]            write_address,
    input  camera_pkg::rgb_pixel_t pixel,
    input  logic [15:0]            read_address,
    output logic [7:0]             read_data
);

    localparam int ADDR_W = $clog2(FRAME_PIXELS);

    logic [7:0] memory [FRAME_PIXELS];
    logic [9:0] grey_sum;

    // Luma approximation (r + 2g + b) / 4
    assign grey_sum = 10'(pixel.red) + {1'b0, pixel.green, 1'b0} + 10'(pixel.blue);

    always_ff @(posedge clock_in) begin
        if (write_enable) begin
            memory[write_address[ADDR_W-1:0]] <= grey_sum[9:2];
        end
        read_data <= memory[read_address[ADDR_W-1:0]];
    end

endmodule

/* capture/pixel_counter.sv */
`timescale 1ns/1ps

module pixel_counter #(
    parameter int FRAME_PIXELS = 64
) (
    input  logic        clock_in,
    input  logic        reset_n_in,
    input  logic        count_enable,
    input  logic        count_clear,
    input  logic [1:0]  compression_factor,
    output logic        keep_pixel,
    output logic        frame_done,
    output logic [15:0] stored_count
);

    localparam int INDEX_W = $clog2(FRAME_PIXELS);

    logic [INDEX_W-1:0] pixel_index;
    logic [INDEX_W-1:0] keep_mask;

    // Keep one pixel in 2**compression_factor
    assign keep_mask = ~({INDEX_W{1'b1}} << compression_factor);
    assign keep_pixel = (pixel_index & keep_mask) == '0;
    assign frame_done = pixel_index == INDEX_W'(FRAME_PIXELS - 1);

    always_ff @(posedge clock_in) begin
        if (!reset_n_in || count_clear) begin
            pixel_index <= '0;
            stored_count <= '0;
        end else if (count_enable) begin
            pixel_index <= pixel_index + 1'b1;
            if (keep_pixel) begin
                stored_count <= stored_count + 16'd1;
            end
        end
    end

endmodule

/* common/camera_pkg.sv */
package camera_pkg;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_pixel_t;

    // Byte order matches the metering response sequence
    typedef struct packed {
        logic [7:0] red_center;
        logic [7:0] green_center;
        logic [7:0] blue_center;
        logic [7:0] red_average;
        logic [7:0] green_average;
        logic [7:0] blue_average;
    } metering_t;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_FRAME,
        CAPTURE,
        DONE
    } capture_state_t;

endpackage

/* common/spi_pkg.sv */
package spi_pkg;

    // Host command opcodes, one byte at the start of each transfer
    typedef enum logic [7:0] {
        OP_CAPTURE         = 8'h20,
        OP_BYTES_AVAILABLE = 8'h21,
        OP_READ_DATA       = 8'h22,
        OP_ZOOM            = 8'h23,
        OP_PAN             = 8'h24,
        OP_METERING        = 8'h25,
        OP_COMPRESSION     = 8'h26,
        OP_IMAGE_READY     = 8'h27,
        OP_POWER_SAVE      = 8'h28
    } opcode_t;

    // Decoded view of the transfer in progress
    typedef struct packed {
        opcode_t    op_code;
        // Held until chip select rises
        logic       op_code_valid;
        logic [7:0] operand;
        // Single cycle per completed operand byte
        logic       operand_valid;
        logic [7:0] operand_count;
    } spi_command_t;

endpackage

/* design/camera_top.sv */
`timescale 1ns/1ps

module camera_top #(
    parameter int FRAME_PIXELS = 64
) (
    input  logic                   clock_in,
    input  logic                   reset_n_in,
    input  logic                   cs_n_in,
    input  logic                   sck_in,
    input  logic                   mosi_in,
    output logic                   miso_out,
    input  logic                   frame_start_in,
    input  logic                   pixel_valid_in,
    input  camera_pkg::rgb_pixel_t pixel_in
);

    spi_pkg::spi_command_t command;
    logic [7:0]            response;
    logic                  response_valid;
    logic                  start_capture;
    logic                  power_save_enable;
    logic [1:0]            compression_factor;
    logic [15:0]           image_address;
    logic                  image_ready;
    logic [15:0]           stored_count;
    logic [7:0]            image_data;
    camera_pkg::metering_t metering_value;
    logic                  count_enable;
    logic                  count_clear;
    logic                  write_enable;
    logic                  keep_pixel;
    logic                  frame_done;

    spi_peripheral u_spi_peripheral (
        .clock_in       (clock_in),
        .reset_n_in     (reset_n_in),
        .cs_n_in        (cs_n_in),
        .sck_in         (sck_in),
        .mosi_in        (mosi_in),
        .miso_out       (miso_out),
        .command        (command),
        .response       (response),
        .response_valid (response_valid)
    );

    spi_registers u_spi_registers (
        .clock_in           (clock_in),
        .reset_n_in         (reset_n_in),
        .command            (command),
        .response           (response),
        .response_valid     (response_valid),
        .start_capture      (start_capture),
        .power_save_enable  (power_save_enable),
        .compression_factor (compression_factor),
        .image_address      (image_address),
        .image_ready        (image_ready),
        .image_total_size   (stored_count),
        .image_data         (image_data),
        .metering           (metering_value)
    );

    capture_fsm #(.FRAME_PIXELS(FRAME_PIXELS)) u_capture_fsm (
        .clock_in          (clock_in),
        .reset_n_in        (reset_n_in),
        .start_capture     (start_capture),
        .power_save_enable (power_save_enable),
        .frame_start_in    (frame_start_in),
        .pixel_valid_in    (pixel_valid_in),
        .keep_pixel        (keep_pixel),
        .frame_done        (frame_done),
        .count_enable      (count_enable),
        .count_clear       (count_clear),
        .write_enable      (write_enable),
        .image_ready       (image_ready)
    );

    pixel_counter #(.FRAME_PIXELS(FRAME_PIXELS)) u_pixel_counter (
        .clock_in           (clock_in),
        .reset_n_in         (reset_n_in),
        .count_enable       (count_enable),
        .count_clear        (count_clear),
        .compression_factor (compression_factor),
        .keep_pixel         (keep_pixel),
        .frame_done         (frame_done),
        .stored_count       (stored_count)
    );

    image_buffer #(.FRAME_PIXELS(FRAME_PIXELS)) u_image_buffer (
        .clock_in      (clock_in),
        .write_enable  (write_enable),
        .write_address (stored_count),
        .pixel         (pixel_in),
        .read_address  (image_address),
        .read_data     (image_data)
    );

    metering #(.FRAME_PIXELS(FRAME_PIXELS)) u_metering (
        .clock_in     (clock_in),
        .reset_n_in   (reset_n_in),
        .count_enable (count_enable),
        .frame_done   (frame_done),
        .count_clear  (count_clear),
        .pixel        (pixel_in),
        .metering     (metering_value)
    );

endmodule

/* design/metering.sv */
`timescale 1ns/1ps

module metering #(
    parameter int FRAME_PIXELS = 64
) (
    input  logic                   clock_in,
    input  logic                   reset_n_in,
    input  logic                   count_enable,
    input  logic                   frame_done,
    input  logic                   count_clear,
    input  camera_pkg::rgb_pixel_t pixel,
    output camera_pkg::metering_t  metering
);

    localparam int INDEX_W = $clog2(FRAME_PIXELS);
    localparam int SUM_W = 8 + INDEX_W;

    logic [INDEX_W-1:0]     pixel_index;
    logic [SUM_W-1:0]       red_sum;
    logic [SUM_W-1:0]       green_sum;
    logic [SUM_W-1:0]       blue_sum;
    logic [SUM_W-1:0]       red_total;
    logic [SUM_W-1:0]       green_total;
    logic [SUM_W-1:0]       blue_total;
    camera_pkg::rgb_pixel_t center;

    // Running sums including the current pixel
    assign red_total = red_sum + SUM_W'(pixel.red);
    assign green_total = green_sum + SUM_W'(pixel.green);
    assign blue_total = blue_sum + SUM_W'(pixel.blue);

    always_ff @(posedge clock_in) begin
        if (count_enable && pixel_index == INDEX_W'(FRAME_PIXELS / 2)) begin
            center <= pixel;
        end
    end

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            pixel_index <= '0;
            red_sum <= '0;
            green_sum <= '0;
            blue_sum <= '0;
            metering <= '0;
        end else if (count_clear) begin
            pixel_index <= '0;
            red_sum <= '0;
            green_sum <= '0;
            blue_sum <= '0;
        end else if (count_enable) begin
            pixel_index <= pixel_index + 1'b1;
            red_sum <= red_total;
            green_sum <= green_total;
            blue_sum <= blue_total;
            // Publish the whole set together at the end of the frame
            if (frame_done) begin
                metering.red_center <= center.red;
                metering.green_center <= center.green;
                metering.blue_center <= center.blue;
                metering.red_average <= red_total[SUM_W-1:INDEX_W];
                metering.green_average <= green_total[SUM_W-1:INDEX_W];
                metering.blue_average <= blue_total[SUM_W-1:INDEX_W];
            end
        end
    end

endmodule

/* design/spi_peripheral.sv */
`timescale 1ns/1ps

module spi_peripheral (
    input  logic                  clock_in,
    input  logic                  reset_n_in,
    input  logic                  cs_n_in,
    input  logic                  sck_in,
    input  logic                  mosi_in,
    output logic                  miso_out,
    output spi_pkg::spi_command_t command,
    input  logic [7:0]            response,
    input  logic                  response_valid
);

    // Pin synchronizers
    logic [1:0] cs_n_sync;
    logic [1:0] sck_sync;
    logic [1:0] mosi_sync;
    logic       sck_last;
    logic       sck_rise;
    logic       sck_fall;

    logic [2:0] bit_count;
    logic [6:0] rx_shift;
    logic [7:0] rx_byte;
    logic [7:0] tx_shift;
    logic       load_pending;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            cs_n_sync <= 2'b11;
            sck_sync <= '0;
            mosi_sync <= '0;
            sck_last <= 1'b0;
        end else begin
            cs_n_sync <= {cs_n_sync[0], cs_n_in};
            sck_sync <= {sck_sync[0], sck_in};
            mosi_sync <= {mosi_sync[0], mosi_in};
            sck_last <= sck_sync[1];
        end
    end

    assign sck_rise = sck_sync[1] & ~sck_last;
    assign sck_fall = ~sck_sync[1] & sck_last;
    assign rx_byte = {rx_shift, mosi_sync[1]};
    assign miso_out = tx_shift[7];

    always_ff @(posedge clock_in) begin
        if (!reset_n_in || cs_n_sync[1]) begin
            bit_count <= '0;
            rx_shift <= '0;
            tx_shift <= '0;
            load_pending <= 1'b0;
            command <= '0;
        end else begin
            command.operand_valid <= 1'b0;
            if (command.operand_valid) begin
                command.operand_count <= command.operand_count + 8'd1;
            end

            // Sample on rising edges, MSB first
            if (sck_rise) begin
                rx_shift <= rx_byte[6:0];
                bit_count <= bit_count + 3'd1;
                if (bit_count == 3'd7) begin
                    load_pending <= 1'b1;
                    if (!command.op_code_valid) begin
                        command.op_code <= spi_pkg::opcode_t'(rx_byte);
                        command.op_code_valid <= 1'b1;
                    end else begin
                        command.operand <= rx_byte;
                        command.operand_valid <= 1'b1;
                    end
                end
            end

            // First falling edge of a new byte picks up the response
            if (sck_fall) begin
                if (load_pending) begin
                    tx_shift <= response_valid ? response : 8'h00;
                    load_pending <= 1'b0;
                end else begin
                    tx_shift <= {tx_shift[6:0], 1'b0};
                end
            end
        end
    end

endmodule

/* design/spi_registers.sv */
`timescale 1ns/1ps

module spi_registers (
    input  logic                  clock_in,
    input  logic                  reset_n_in,
    input  spi_pkg::spi_command_t command,
    output logic [7:0]            response,
    output logic                  response_valid,
    output logic                  start_capture,
    output logic                  power_save_enable,
    output logic [1:0]            compression_factor,
    output logic [15:0]           image_address,
    input  logic                  image_ready,
    input  logic [15:0]           image_total_size,
    input  logic [7:0]            image_data,
    input  camera_pkg::metering_t metering
);

    logic [15:0] bytes_remaining;
    logic        capture_issued;

    assign bytes_remaining = image_total_size - image_address;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            response <= '0;
            response_valid <= 1'b0;
            start_capture <= 1'b0;
            power_save_enable <= 1'b0;
            compression_factor <= '0;
            image_address <= '0;
            capture_issued <= 1'b0;
        end else begin
            start_capture <= 1'b0;
            response_valid <= 1'b0;

            if (!command.op_code_valid) begin
                capture_issued <= 1'b0;
            end else begin
                case (command.op_code)
                    spi_pkg::OP_CAPTURE: begin
                        // One request per transfer
                        if (!capture_issued) begin
                            start_capture <= 1'b1;
                            capture_issued <= 1'b1;
                            image_address <= '0;
                        end
                    end
                    spi_pkg::OP_BYTES_AVAILABLE: begin
                        response_valid <= 1'b1;
                        case (command.operand_count)
                            8'd0: response <= bytes_remaining[15:8];
                            8'd1: response <= bytes_remaining[7:0];
                            default: response <= '0;
                        endcase
                    end
                    spi_pkg::OP_READ_DATA: begin
                        response_valid <= 1'b1;
                        // Past the end the last byte stays in response
                        if (image_address < image_total_size) begin
                            response <= image_data;
                            if (command.operand_valid) begin
                                image_address <= image_address + 16'd1;
                            end
                        end
                    end
                    spi_pkg::OP_METERING: begin
                        response_valid <= 1'b1;
                        case (command.operand_count)
                            8'd0: response <= metering.red_center;
                            8'd1: response <= metering.green_center;
                            8'd2: response <= metering.blue_center;
                            8'd3: response <= metering.red_average;
                            8'd4: response <= metering.green_average;
                            8'd5: response <= metering.blue_average;
                            default: response <= '0;
                        endcase
                    end
                    spi_pkg::OP_COMPRESSION: begin
                        if (command.operand_valid) begin
                            compression_factor <= command.operand[1:0];
                        end
                    end
                    spi_pkg::OP_IMAGE_READY: begin
                        response_valid <= 1'b1;
                        response <= {7'b0, image_ready};
                    end
                    spi_pkg::OP_POWER_SAVE: begin
                        if (command.operand_valid) begin
                            power_save_enable <= command.operand[0];
                        end
                    end
                    // Zoom and pan operands are taken but have no hardware
                    default: ;
                endcase
            end
        end
    end

endmodule

/* files.f */
+incdir+tb
common/spi_pkg.sv
common/camera_pkg.sv
design/spi_peripheral.sv
design/spi_registers.sv
capture/capture_fsm.sv
capture/pixel_counter.sv
capture/image_buffer.sv
design/metering.sv
design/camera_top.sv
tb/camera_tb.sv

/* tb/spi_host_tasks.svh */
// SPI host side, mode 0, most significant bit first

// Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
endfunction

// One LFSR step per bit taken
task automatic random_byte(output logic [7:0] value);
    value = '0;
    repeat (8) begin
        lfsr_state = lfsr_step(lfsr_state);
        value = {value[6:0], lfsr_state[0]};
    end
endtask

task automatic begin_transfer();
    cs_n_in = 1'b0;
    repeat (HALF_SCK) @(negedge clock_in);
endtask

// MOSI changes while sck is low, MISO is taken at the rising edge
task automatic transfer_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
        mosi_in = tx[i];
        repeat (HALF_SCK) @(negedge clock_in);
        sck_in = 1'b1;
        rx[i] = miso_out;
        repeat (HALF_SCK) @(negedge clock_in);
        sck_in = 1'b0;
    end
endtask

task automatic end_transfer();
    repeat (HALF_SCK) @(negedge clock_in);
    cs_n_in = 1'b1;
    mosi_in = 1'b0;
    // Idle gap with chip select high
    repeat (HALF_SCK) @(negedge clock_in);
endtask

// Opcode, then a number of identical operand bytes, replies land in rx_bytes
task automatic run_command(input logic [7:0] op_code, input int operands,
                           input logic [7:0] operand);
    logic [7:0] ignored;
    begin_transfer();
    transfer_byte(op_code, ignored);
    for (int i = 0; i < operands; i++) begin
        transfer_byte(operand, rx_bytes[i]);
    end
    end_transfer();
endtask

/* tb/camera_tb.sv */
`timescale 1ns/1ps

module camera_tb;

    localparam int FRAME_PIXELS = 64;
    localparam int HALF_SCK = 8;
    localparam int FRAME_CYCLES = 1 + 2 * FRAME_PIXELS;
    localparam int SPI_BYTES = 200;
    // Four frames plus every SPI byte, doubled for margin
    localparam int CYCLE_LIMIT = 4 * FRAME_CYCLES + 2 * SPI_BYTES * 16 * HALF_SCK;

    logic                   clock_in;
    logic                   reset_n_in;
    logic                   cs_n_in;
    logic                   sck_in;
    logic                   mosi_in;
    logic                   miso_out;
    logic                   frame_start_in;
    logic                   pixel_valid_in;
    camera_pkg::rgb_pixel_t pixel_in;

    logic [15:0]            lfsr_state = 16'd90;
    camera_pkg::rgb_pixel_t model [FRAME_PIXELS];
    logic [7:0]             rx_bytes [80];
    int                     frame_count = 0;
    int                     target_frame = -1;
    int                     errors = 0;
    int                     checks = 0;
    int                     tests_run = 0;
    int                     tests_failed = 0;
    int                     cycle_count = 0;

    `include "spi_host_tasks.svh"

    camera_top #(.FRAME_PIXELS(FRAME_PIXELS)) u_camera_top (
        .clock_in       (clock_in),
        .reset_n_in     (reset_n_in),
        .cs_n_in        (cs_n_in),
        .sck_in         (sck_in),
        .mosi_in        (mosi_in),
        .miso_out       (miso_out),
        .frame_start_in (frame_start_in),
        .pixel_valid_in (pixel_valid_in),
        .pixel_in       (pixel_in)
    );

    initial begin
        clock_in = 1'b0;
        forever #20 clock_in = ~clock_in;
    end

    initial begin : watchdog
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clock_in);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("TB FAILED");
        $finish;
    end

    // Frame start, then pixels on alternate cycles, without pause
    initial begin : pixel_stream
        camera_pkg::rgb_pixel_t next_pixel;
        logic                   recording;
        wait (reset_n_in);
        forever begin
            @(negedge clock_in);
            pixel_valid_in = 1'b0;
            frame_start_in = 1'b1;
            recording = (frame_count == target_frame);
            frame_count++;
            for (int i = 0; i < FRAME_PIXELS; i++) begin
                @(negedge clock_in);
                frame_start_in = 1'b0;
                random_byte(next_pixel.red);
                random_byte(next_pixel.green);
                random_byte(next_pixel.blue);
                pixel_in = next_pixel;
                pixel_valid_in = 1'b1;
                if (recording) begin
                    model[i] = next_pixel;
                end
                @(negedge clock_in);
                pixel_valid_in = 1'b0;
            end
        end
    end

    function automatic logic [7:0] grey_of(input camera_pkg::rgb_pixel_t p);
        int sum;
        sum = p.red + 2 * p.green + p.blue;
        return sum / 4;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic wait_frames(input int count);
        int goal;
        goal = frame_count + count;
        wait (frame_count >= goal);
    endtask

    // Command sent mid frame, so the capture takes the first frame after it
    task automatic request_capture(input bit record_frame);
        wait_frames(1);
        repeat (FRAME_PIXELS) @(negedge clock_in);
        run_command(spi_pkg::OP_CAPTURE, 0, 8'h00);
        if (record_frame) begin
            target_frame = frame_count;
        end
    endtask

    task automatic wait_image_ready();
        do begin
            run_command(spi_pkg::OP_IMAGE_READY, 1, 8'h00);
        end while (rx_bytes[0] !== 8'h01);
    endtask

    task automatic check_available(input string name, input int expected);
        run_command(spi_pkg::OP_BYTES_AVAILABLE, 2, 8'h00);
        check_value(name, expected, {rx_bytes[0], rx_bytes[1]});
    endtask

    // Past the stored size the last byte repeats
    task automatic check_image(input string name, input int first, input int count,
                               input int step, input int stored);
        int index;
        run_command(spi_pkg::OP_READ_DATA, count, 8'h00);
        for (int i = 0; i < count; i++) begin
            index = (first + i > stored - 1) ? stored - 1 : first + i;
            check_value(name, grey_of(model[index * step]), rx_bytes[i]);
        end
    endtask

    task automatic check_metering();
        int sum_red;
        int sum_green;
        int sum_blue;
        sum_red = 0;
        sum_green = 0;
        sum_blue = 0;
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            sum_red += model[i].red;
            sum_green += model[i].green;
            sum_blue += model[i].blue;
        end
        run_command(spi_pkg::OP_METERING, 6, 8'h00);
        check_value("center_red", model[FRAME_PIXELS / 2].red, rx_bytes[0]);
        check_value("center_green", model[FRAME_PIXELS / 2].green, rx_bytes[1]);
        check_value("center_blue", model[FRAME_PIXELS / 2].blue, rx_bytes[2]);
        check_value("average_red", sum_red / FRAME_PIXELS, rx_bytes[3]);
        check_value("average_green", sum_green / FRAME_PIXELS, rx_bytes[4]);
        check_value("average_blue", sum_blue / FRAME_PIXELS, rx_bytes[5]);
    endtask

    initial begin
        int mark;
        reset_n_in = 1'b0;
        cs_n_in = 1'b1;
        sck_in = 1'b0;
        mosi_in = 1'b0;
        frame_start_in = 1'b0;
        pixel_valid_in = 1'b0;
        pixel_in = '0;
        repeat (4) @(negedge clock_in);
        reset_n_in = 1'b1;

        mark = errors;
        run_command(spi_pkg::OP_IMAGE_READY, 1, 8'h00);
        check_value("reset_ready", 0, rx_bytes[0]);
        check_available("reset_available", 0);
        report_test("reset_state", mark);

        mark = errors;
        run_command(spi_pkg::OP_COMPRESSION, 1, 8'd0);
        request_capture(1'b1);
        wait_image_ready();
        check_available("full_available", FRAME_PIXELS);
        check_image("full_image", 0, FRAME_PIXELS, 1, FRAME_PIXELS);
        report_test("full_frame", mark);

        mark = errors;
        check_metering();
        report_test("metering", mark);

        // Every fourth pixel kept
        mark = errors;
        run_command(spi_pkg::OP_COMPRESSION, 1, 8'd2);
        request_capture(1'b1);
        wait_image_ready();
        check_available("quarter_available", 16);
        check_image("quarter_head", 0, 5, 4, 16);
        report_test("compressed_frame", mark);

        mark = errors;
        check_available("partial_available", 11);
        check_image("quarter_tail", 5, 14, 4, 16);
        check_available("drained_available", 0);
        report_test("read_past_end", mark);

        // Capture ignored while power saving, previous image stays
        mark = errors;
        run_command(spi_pkg::OP_POWER_SAVE, 1, 8'd1);
        request_capture(1'b0);
        wait_frames(2);
        run_command(spi_pkg::OP_ZOOM, 1, 8'h5a);
        run_command(spi_pkg::OP_PAN, 1, 8'ha5);
        run_command(spi_pkg::OP_IMAGE_READY, 1, 8'h00);
        check_value("saved_ready", 1, rx_bytes[0]);
        check_available("saved_available", 16);
        check_image("saved_image", 0, 16, 4, 16);
        run_command(spi_pkg::OP_POWER_SAVE, 1, 8'd0);
        request_capture(1'b1);
        wait_image_ready();
        check_available("resumed_available", 16);
        check_image("resumed_image", 0, 16, 4, 16);
        report_test("power_save", mark);

        $display("tests %0d, failing tests %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
